//--- rtl/mem_stage_defs.svh
// widths, region limits and stack depth for the memory stage
// region limits are byte addresses and assume a 32-bit address bus
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// ==============================
// bus widths
// ==============================
`define MS_ADDR_W 32
`define MS_DATA_W 32

// ==============================
// address map
// ==============================
// first byte address above data memory
`define MS_DMEM_LIMIT 32'h0000_8000
// first byte address of the stack RAM
`define MS_STACK_BASE 32'h0002_0000

// stack RAM size in words, power of two
`define MS_STACK_DEPTH 4096

`endif

//--- rtl/ahb_pkg.sv
// AHB-Lite master side types for single word transfers
// only IDLE and NONSEQ are ever issued by this design
package ahb_pkg;

	// transfer type encoding
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// transfer attributes
	typedef logic [2:0] hsize_t;
	typedef logic [2:0] hburst_t;
	typedef logic [3:0] hprot_t;

	// 32-bit word transfers
	localparam hsize_t HSIZE_WORD = 3'b010;
	// single beat, no burst
	localparam hburst_t HBURST_SINGLE = 3'b000;
	// no protection attributes
	localparam hprot_t HPROT_NONE = 4'h0;

endpackage

//--- rtl/mem_stage_pkg.sv
// data path types and FSM encodings of the memory stage
// region_t order has no meaning beyond the decode itself
`include "mem_stage_defs.svh"

package mem_stage_pkg;

	// ==============================
	// data path words
	// ==============================
	typedef logic [`MS_ADDR_W-1:0] addr_t;
	typedef logic [`MS_DATA_W-1:0] data_t;

	// address regions
	typedef enum logic [1:0]
	{
		REGION_DMEM  = 2'd0,
		REGION_PERI  = 2'd1,
		REGION_STACK = 2'd2
	} region_t;

	// peripheral master FSM
	typedef enum logic
	{
		PERI_IDLE   = 1'b0,
		PERI_NONSEQ = 1'b1
	} peri_state_t;

endpackage

//--- rtl/region_req_if.sv
// region-qualified load/store request from the address decoder
// read and write are never high together
`timescale 1ns/1ps

interface region_req_if;

	// strobes, already qualified by region
	logic                 read;
	logic                 write;
	// byte address and store data
	mem_stage_pkg::addr_t addr;
	mem_stage_pkg::data_t wdata;

	// decoder side
	modport issuer
	(
		output read,
		output write,
		output addr,
		output wdata
	);

	// region target side
	modport target
	(
		input read,
		input write,
		input addr,
		input wdata
	);

endinterface

//--- rtl/addr_decoder.sv
// classifies one load/store by address into dmem, peripheral or stack
// purely combinational, request levels pass straight through
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module addr_decoder
(
	input  logic                   i_read,
	input  logic                   i_write,
	input  mem_stage_pkg::addr_t   i_addr,
	input  mem_stage_pkg::data_t   i_wdata,
	output mem_stage_pkg::region_t o_region,
	output logic                   o_dmem_read,
	output logic                   o_dmem_write,
	region_req_if.issuer           stack_req,
	region_req_if.issuer           peri_req
);

	// ==============================
	// region decode
	// ==============================
	always_comb
	begin
		// below the dmem limit
		if (i_addr < `MS_DMEM_LIMIT)
			o_region = mem_stage_pkg::REGION_DMEM;
		// stack sits at the top of the map
		else if (i_addr >= `MS_STACK_BASE)
			o_region = mem_stage_pkg::REGION_STACK;
		// everything in between goes out on AHB
		else
			o_region = mem_stage_pkg::REGION_PERI;
	end

	// ==============================
	// per-region strobes
	// ==============================
	// data memory leaves as plain strobes
	assign o_dmem_read  = i_read  && (o_region == mem_stage_pkg::REGION_DMEM);
	assign o_dmem_write = i_write && (o_region == mem_stage_pkg::REGION_DMEM);

	// stack RAM request
	assign stack_req.read  = i_read  && (o_region == mem_stage_pkg::REGION_STACK);
	assign stack_req.write = i_write && (o_region == mem_stage_pkg::REGION_STACK);
	assign stack_req.addr  = i_addr;
	assign stack_req.wdata = i_wdata;

	// peripheral request
	assign peri_req.read  = i_read  && (o_region == mem_stage_pkg::REGION_PERI);
	assign peri_req.write = i_write && (o_region == mem_stage_pkg::REGION_PERI);
	assign peri_req.addr  = i_addr;
	assign peri_req.wdata = i_wdata;

endmodule

//--- rtl/stack_ram.sv
// single-port word RAM for the stack region
// DEPTH must be a power of two and at least 2, higher address bits wrap
// write on the clock edge, combinational read
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module stack_ram
#(
	parameter int DEPTH = `MS_STACK_DEPTH
)
(
	input  logic                 clk,
	region_req_if.target         req,
	output mem_stage_pkg::data_t o_rdata
);

	// word index width
	localparam int IDX_W = $clog2(DEPTH);

	// ==============================
	// storage
	// ==============================
	mem_stage_pkg::data_t mem [DEPTH];
	logic [IDX_W-1:0]     word_idx;

	// drop the byte offset, wrap modulo depth
	assign word_idx = req.addr[IDX_W+1:2];

	// store lands at the edge of the request cycle
	always_ff @(posedge clk)
	begin
		if (req.write)
			mem[word_idx] <= req.wdata;
	end

	// load word only while a stack read is up
	assign o_rdata = req.read ? mem[word_idx] : '0;

endmodule

//--- rtl/ahb_peri_master.sv
// single-transfer AHB-Lite master for the peripheral region
// one NONSEQ per request, the requester holds its levels while o_stall is high
// haddr and hwdata follow the request, so they stay valid through the data phase
`timescale 1ns/1ps

module ahb_peri_master
(
	input  logic                   clk,
	input  logic                   rst_n,
	region_req_if.target           req,
	input  logic                   i_hreadyout,
	input  logic                   i_hresp,
	input  mem_stage_pkg::data_t   i_hrdata,
	output ahb_pkg::htrans_t       o_htrans,
	output logic                   o_hwrite,
	output mem_stage_pkg::addr_t   o_haddr,
	output mem_stage_pkg::data_t   o_hwdata,
	output mem_stage_pkg::data_t   o_rdata,
	output logic                   o_stall,
	output logic                   o_dec_err
);

	mem_stage_pkg::peri_state_t state;
	mem_stage_pkg::peri_state_t state_nxt;
	// any peripheral access pending
	logic                       req_any;

	assign req_any = req.read || req.write;

	// ==============================
	// state register
	// ==============================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= mem_stage_pkg::PERI_IDLE;
		else
			state <= state_nxt;
	end

	// direction is captured while idle and held for the transfer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_hwrite <= 1'b0;
		else if (state == mem_stage_pkg::PERI_IDLE)
			o_hwrite <= req.write;
	end

	// ==============================
	// next state, htrans and stall
	// ==============================
	always_comb
	begin
		state_nxt = state;
		o_htrans  = ahb_pkg::IDLE;
		o_stall   = 1'b0;
		unique case (state)
			mem_stage_pkg::PERI_IDLE:
			begin
				// request cycle, bus still idle
				o_stall = req_any;
				if (req_any)
					state_nxt = mem_stage_pkg::PERI_NONSEQ;
			end
			mem_stage_pkg::PERI_NONSEQ:
			begin
				o_htrans = ahb_pkg::NONSEQ;
				// slave wait states keep us here
				o_stall  = !i_hreadyout;
				// first ready cycle completes the transfer
				if (i_hreadyout)
					state_nxt = mem_stage_pkg::PERI_IDLE;
			end
			default:
			begin
				state_nxt = mem_stage_pkg::PERI_IDLE;
			end
		endcase
	end

	// ==============================
	// address and data
	// ==============================
	assign o_haddr  = req.addr;
	assign o_hwdata = req.wdata;
	// read data is taken in the completing cycle
	assign o_rdata  = i_hrdata;

	// error response seen by the master
	assign o_dec_err = i_hreadyout && i_hresp;

endmodule

//--- rtl/load_return.sv
// memory-to-writeback register for loaded words
// o_load_valid pulses one cycle after a read that is not stalled
`timescale 1ns/1ps

module load_return
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_read,
	input  logic                   i_stall,
	input  mem_stage_pkg::region_t i_region,
	input  mem_stage_pkg::data_t   i_dmem_rdata,
	input  mem_stage_pkg::data_t   i_stack_rdata,
	input  mem_stage_pkg::data_t   i_peri_rdata,
	output logic                   o_load_valid,
	output mem_stage_pkg::data_t   o_load_data
);

	mem_stage_pkg::data_t rdata_sel;
	// read finishes this cycle
	logic                 load_done;

	assign load_done = i_read && !i_stall;

	// ==============================
	// word select by region
	// ==============================
	always_comb
	begin
		unique case (i_region)
			mem_stage_pkg::REGION_DMEM:  rdata_sel = i_dmem_rdata;
			mem_stage_pkg::REGION_PERI:  rdata_sel = i_peri_rdata;
			mem_stage_pkg::REGION_STACK: rdata_sel = i_stack_rdata;
			default:                     rdata_sel = '0;
		endcase
	end

	// valid pulse
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_load_valid <= 1'b0;
		else
			o_load_valid <= load_done;
	end

	// loaded word, held until the next load
	always_ff @(posedge clk)
	begin
		if (load_done)
			o_load_data <= rdata_sel;
	end

endmodule

//--- rtl/mem_stage_top.sv
// memory stage of the pipelined core
// request ports are levels and must hold steady while o_stall is high
// dmem region answers in the same cycle, i_dmem_rdata is sampled with the request
`timescale 1ns/1ps

module mem_stage_top
(
	input  logic                 clk,
	input  logic                 rst_n,
	// load/store request
	input  logic                 i_read,
	input  logic                 i_write,
	input  mem_stage_pkg::addr_t i_addr,
	input  mem_stage_pkg::data_t i_wdata,
	output logic                 o_stall,
	// data memory
	input  mem_stage_pkg::data_t i_dmem_rdata,
	output logic                 o_dmem_read,
	output logic                 o_dmem_write,
	output mem_stage_pkg::addr_t o_dmem_addr,
	output mem_stage_pkg::data_t o_dmem_wdata,
	// AHB-Lite peripheral bus
	input  logic                 i_hreadyout,
	input  logic                 i_hresp,
	input  mem_stage_pkg::data_t i_hrdata,
	output ahb_pkg::htrans_t     o_htrans,
	output logic                 o_hwrite,
	output mem_stage_pkg::addr_t o_haddr,
	output mem_stage_pkg::data_t o_hwdata,
	output ahb_pkg::hsize_t      o_hsize,
	output ahb_pkg::hburst_t     o_hburst,
	output ahb_pkg::hprot_t      o_hprot,
	output logic                 o_peri_dec_err,
	// writeback side
	output logic                 o_load_valid,
	output mem_stage_pkg::data_t o_load_data
);

	mem_stage_pkg::region_t region;
	mem_stage_pkg::data_t   stack_rdata;
	mem_stage_pkg::data_t   peri_rdata;

	region_req_if stack_req ();
	region_req_if peri_req ();

	// ==============================
	// input side
	// ==============================
	addr_decoder u_addr_decoder
	(
		.i_read       (i_read),
		.i_write      (i_write),
		.i_addr       (i_addr),
		.i_wdata      (i_wdata),
		.o_region     (region),
		.o_dmem_read  (o_dmem_read),
		.o_dmem_write (o_dmem_write),
		.stack_req    (stack_req.issuer),
		.peri_req     (peri_req.issuer)
	);

	assign o_dmem_addr  = i_addr;
	assign o_dmem_wdata = i_wdata;

	// ==============================
	// targets
	// ==============================
	stack_ram u_stack_ram
	(
		.clk     (clk),
		.req     (stack_req.target),
		.o_rdata (stack_rdata)
	);

	ahb_peri_master u_ahb_peri_master
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (peri_req.target),
		.i_hreadyout (i_hreadyout),
		.i_hresp     (i_hresp),
		.i_hrdata    (i_hrdata),
		.o_htrans    (o_htrans),
		.o_hwrite    (o_hwrite),
		.o_haddr     (o_haddr),
		.o_hwdata    (o_hwdata),
		.o_rdata     (peri_rdata),
		.o_stall     (o_stall),
		.o_dec_err   (o_peri_dec_err)
	);

	// fixed transfer attributes
	assign o_hsize  = ahb_pkg::HSIZE_WORD;
	assign o_hburst = ahb_pkg::HBURST_SINGLE;
	assign o_hprot  = ahb_pkg::HPROT_NONE;

	// ==============================
	// output side
	// ==============================
	load_return u_load_return
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.i_read        (i_read),
		.i_stall       (o_stall),
		.i_region      (region),
		.i_dmem_rdata  (i_dmem_rdata),
		.i_stack_rdata (stack_rdata),
		.i_peri_rdata  (peri_rdata),
		.o_load_valid  (o_load_valid),
		.o_load_data   (o_load_data)
	);

endmodule

//--- verif/tb_mem_stage.sv
// directed testbench for the memory stage with a wait-state AHB slave model
// the slave never stretches an IDLE cycle and answers each NONSEQ once
// outputs sampled on the falling edge and inputs driven on the rising edge
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module tb_mem_stage;

	logic                 clk;
	logic                 rst_n;
	logic                 i_read;
	logic                 i_write;
	mem_stage_pkg::addr_t i_addr;
	mem_stage_pkg::data_t i_wdata;
	mem_stage_pkg::data_t i_dmem_rdata;
	logic                 i_hreadyout = 1'b0;
	logic                 i_hresp     = 1'b0;
	mem_stage_pkg::data_t i_hrdata    = '0;
	logic                 o_stall;
	logic                 o_dmem_read;
	logic                 o_dmem_write;
	mem_stage_pkg::addr_t o_dmem_addr;
	mem_stage_pkg::data_t o_dmem_wdata;
	ahb_pkg::htrans_t     o_htrans;
	logic                 o_hwrite;
	mem_stage_pkg::addr_t o_haddr;
	mem_stage_pkg::data_t o_hwdata;
	ahb_pkg::hsize_t      o_hsize;
	ahb_pkg::hburst_t     o_hburst;
	ahb_pkg::hprot_t      o_hprot;
	logic                 o_peri_dec_err;
	logic                 o_load_valid;
	mem_stage_pkg::data_t o_load_data;

	// slave model knobs set by the tests
	int                   wait_states = 0;
	int                   wait_cnt    = 0;
	logic                 slave_err   = 1'b0;
	mem_stage_pkg::data_t slave_rdata = '0;

	// bookkeeping
	string                cur_test;
	int                   errors       = 0;
	int                   errs_at_open = 0;
	int                   tests_run    = 0;
	int                   tests_failed = 0;

	mem_stage_top uut
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.i_read         (i_read),
		.i_write        (i_write),
		.i_addr         (i_addr),
		.i_wdata        (i_wdata),
		.o_stall        (o_stall),
		.i_dmem_rdata   (i_dmem_rdata),
		.o_dmem_read    (o_dmem_read),
		.o_dmem_write   (o_dmem_write),
		.o_dmem_addr    (o_dmem_addr),
		.o_dmem_wdata   (o_dmem_wdata),
		.i_hreadyout    (i_hreadyout),
		.i_hresp        (i_hresp),
		.i_hrdata       (i_hrdata),
		.o_htrans       (o_htrans),
		.o_hwrite       (o_hwrite),
		.o_haddr        (o_haddr),
		.o_hwdata       (o_hwdata),
		.o_hsize        (o_hsize),
		.o_hburst       (o_hburst),
		.o_hprot        (o_hprot),
		.o_peri_dec_err (o_peri_dec_err),
		.o_load_valid   (o_load_valid),
		.o_load_data    (o_load_data)
	);

	// 100 ns clock
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==============================
	// AHB slave model
	// ==============================
	// first NONSEQ cycle always low
	// then wait_states low cycles and one ready cycle
	always @(posedge clk)
	begin
		if (o_htrans == ahb_pkg::NONSEQ && !i_hreadyout)
		begin
			if (wait_cnt == 0)
			begin
				// completing cycle
				i_hreadyout <= 1'b1;
				i_hresp     <= slave_err;
				i_hrdata    <= slave_rdata;
			end
			else
				wait_cnt <= wait_cnt - 1;
		end
		else
		begin
			// reload the wait counter between transfers
			i_hreadyout <= 1'b0;
			i_hresp     <= 1'b0;
			wait_cnt    <= wait_states;
		end
	end

	// ==============================
	// compare tasks
	// ==============================
	task automatic data_check(input string what, input mem_stage_pkg::data_t exp,
		input mem_stage_pkg::data_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic addr_check(input string what, input mem_stage_pkg::addr_t exp,
		input mem_stage_pkg::addr_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic htrans_check(input string what, input ahb_pkg::htrans_t exp,
		input ahb_pkg::htrans_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %s actual %s", cur_test, what,
				exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic hsize_check(input string what, input ahb_pkg::hsize_t exp,
		input ahb_pkg::hsize_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %b actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic hburst_check(input string what, input ahb_pkg::hburst_t exp,
		input ahb_pkg::hburst_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %b actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic hprot_check(input string what, input ahb_pkg::hprot_t exp,
		input ahb_pkg::hprot_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %b actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic flag_check(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %b actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	// ==============================
	// helpers
	// ==============================
	task automatic open_test(input string name);
		cur_test     = name;
		errs_at_open = errors;
		tests_run++;
	endtask

	// one result line per test
	task automatic close_test();
		if (errors == errs_at_open)
			$display("%s: ok", cur_test);
		else
		begin
			$display("%s: fail with %0d errors", cur_test, errors - errs_at_open);
			tests_failed++;
		end
	endtask

	task automatic await_load_valid(output bit seen);
		int cyc;
		seen = 1'b0;
		for (cyc = 0; cyc < 50 && !seen; cyc++)
		begin
			@(negedge clk);
			if (o_load_valid)
				seen = 1'b1;
		end
		if (!seen)
		begin
			$display("%s: load valid pulse did not arrive within 50 cycles", cur_test);
			errors++;
		end
	endtask

	// one peripheral transfer with the request held until the stall falls
	task automatic peri_transfer(input logic is_write, input mem_stage_pkg::addr_t a,
		input mem_stage_pkg::data_t wd);
		int cyc;
		bit done;
		done = 1'b0;
		@(posedge clk);
		i_read  <= !is_write;
		i_write <= is_write;
		i_addr  <= a;
		i_wdata <= wd;
		@(negedge clk);
		// bus still idle in the request cycle
		flag_check("stall in request cycle", 1'b1, o_stall);
		htrans_check("htrans in request cycle", ahb_pkg::IDLE, o_htrans);
		for (cyc = 0; cyc < 50 && !done; cyc++)
		begin
			@(negedge clk);
			htrans_check("htrans in transfer", ahb_pkg::NONSEQ, o_htrans);
			flag_check("hwrite", is_write, o_hwrite);
			addr_check("haddr", a, o_haddr);
			if (is_write)
				data_check("hwdata", wd, o_hwdata);
			// word size, single beat, no protection bits
			hsize_check("hsize", 3'b010, o_hsize);
			hburst_check("hburst", 3'b000, o_hburst);
			hprot_check("hprot", 4'b0000, o_hprot);
			// stall drops exactly when the slave is ready
			flag_check("stall against hreadyout", !i_hreadyout, o_stall);
			flag_check("decode error", i_hreadyout && slave_err, o_peri_dec_err);
			if (!o_stall)
				done = 1'b1;
		end
		if (!done)
		begin
			$display("%s: stall did not fall within 50 cycles", cur_test);
			errors++;
		end
		@(posedge clk);
		i_read  <= 1'b0;
		i_write <= 1'b0;
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic reset_state();
		open_test("reset_state");
		@(negedge clk);
		htrans_check("htrans", ahb_pkg::IDLE, o_htrans);
		flag_check("hwrite", 1'b0, o_hwrite);
		flag_check("load valid", 1'b0, o_load_valid);
		flag_check("stall", 1'b0, o_stall);
		close_test();
	endtask

	task automatic dmem_access();
		mem_stage_pkg::addr_t a;
		mem_stage_pkg::data_t wd;
		mem_stage_pkg::data_t rd;
		bit seen;
		open_test("dmem_access");
		// word aligned address below the dmem limit
		a  = ($urandom % `MS_DMEM_LIMIT) & ~32'h3;
		wd = $urandom;
		rd = $urandom;
		@(posedge clk);
		i_write <= 1'b1;
		i_addr  <= a;
		i_wdata <= wd;
		@(negedge clk);
		flag_check("dmem write", 1'b1, o_dmem_write);
		addr_check("dmem addr", a, o_dmem_addr);
		data_check("dmem wdata", wd, o_dmem_wdata);
		flag_check("stall on store", 1'b0, o_stall);
		// load with read data offered in the same cycle
		@(posedge clk);
		i_write      <= 1'b0;
		i_read       <= 1'b1;
		i_dmem_rdata <= rd;
		@(negedge clk);
		flag_check("dmem read", 1'b1, o_dmem_read);
		flag_check("stall on load", 1'b0, o_stall);
		@(posedge clk);
		i_read <= 1'b0;
		await_load_valid(seen);
		if (seen)
		begin
			data_check("load data", rd, o_load_data);
			@(negedge clk);
			flag_check("valid is one cycle", 1'b0, o_load_valid);
		end
		close_test();
	endtask

	task automatic stack_round_trip();
		mem_stage_pkg::addr_t a [4];
		mem_stage_pkg::data_t w [4];
		bit seen;
		open_test("stack_round_trip");
		// stores to distinct words
		for (int i = 0; i < 4; i++)
		begin
			a[i] = `MS_STACK_BASE + (i * 20);
			w[i] = $urandom;
			@(posedge clk);
			i_write <= 1'b1;
			i_addr  <= a[i];
			i_wdata <= w[i];
			@(negedge clk);
			htrans_check("htrans on store", ahb_pkg::IDLE, o_htrans);
			flag_check("stall on store", 1'b0, o_stall);
		end
		@(posedge clk);
		i_write <= 1'b0;
		// read back in store order
		for (int i = 0; i < 4; i++)
		begin
			@(posedge clk);
			i_read <= 1'b1;
			i_addr <= a[i];
			@(negedge clk);
			htrans_check("htrans on load", ahb_pkg::IDLE, o_htrans);
			@(posedge clk);
			i_read <= 1'b0;
			await_load_valid(seen);
			if (seen)
				data_check("stack word", w[i], o_load_data);
		end
		close_test();
	endtask

	task automatic peri_store();
		mem_stage_pkg::addr_t a;
		open_test("peri_store");
		// word aligned address in the peripheral window
		a = `MS_DMEM_LIMIT + (($urandom % (`MS_STACK_BASE - `MS_DMEM_LIMIT)) & ~32'h3);
		wait_states = $urandom % 6;
		peri_transfer(1'b1, a, $urandom);
		close_test();
	endtask

	task automatic peri_load();
		mem_stage_pkg::addr_t a;
		bit seen;
		open_test("peri_load");
		a = `MS_DMEM_LIMIT + (($urandom % (`MS_STACK_BASE - `MS_DMEM_LIMIT)) & ~32'h3);
		wait_states = $urandom % 6;
		slave_rdata = $urandom;
		peri_transfer(1'b0, a, '0);
		await_load_valid(seen);
		if (seen)
			data_check("load data", slave_rdata, o_load_data);
		close_test();
	endtask

	task automatic decode_error();
		open_test("decode_error");
		wait_states = $urandom % 6;
		slave_err   = 1'b1;
		peri_transfer(1'b0, `MS_DMEM_LIMIT + 32'h40, '0);
		@(negedge clk);
		slave_err   = 1'b0;
		// error gone once the slave leaves the ready cycle
		flag_check("decode error after transfer", 1'b0, o_peri_dec_err);
		close_test();
	endtask

	initial
	begin
		void'($urandom(33));
		rst_n        = 1'b0;
		i_read       = 1'b0;
		i_write      = 1'b0;
		i_addr       = '0;
		i_wdata      = '0;
		i_dmem_rdata = '0;
		// reset held for 3 cycles
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		reset_state();
		dmem_access();
		stack_round_trip();
		peri_store();
		peri_load();
		decode_error();
		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+rtl
rtl/ahb_pkg.sv
rtl/mem_stage_pkg.sv
rtl/region_req_if.sv
rtl/addr_decoder.sv
rtl/stack_ram.sv
rtl/ahb_peri_master.sv
rtl/load_return.sv
rtl/mem_stage_top.sv
verif/tb_mem_stage.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_mem_stage
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
